// File: Makefile
# Verilator build and run of the fully connected layer testbench

SIM       = verilator
TOP       = fc_layer_tb
FILELIST  = filelist.f
BUILD_DIR = obj_dir
FLAGS     = --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(BUILD_DIR)
PASS_MSG  = ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) -f $(FILELIST)

# The run passes only if the pass message shows up in the output
run: compile
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: dv/fc_layer_assertions.sv
// Handshake and reset properties of the layer top level.
// Bound into fc_layer_top from the testbench.

`timescale 1ns/1ps

module fc_layer_assertions (
   input logic                clk,
   input logic                reset,
   input logic                input_ready,
   input logic                output_valid,
   input logic                output_ready,
   input fc_layer_pkg::data_t output_data
);

   int fail_count = 0;

   valid_low_after_reset: assert property (@(posedge clk) reset |=> !output_valid)
      else begin
         fail_count = fail_count + 1;
         $error("output_valid high during or right after reset");
      end

   // Load and drain never overlap
   no_load_while_draining: assert property (@(posedge clk) disable iff (reset)
      !(input_ready && output_valid))
      else begin
         fail_count = fail_count + 1;
         $error("input_ready and output_valid high together");
      end

   word_held_on_stall: assert property (@(posedge clk) disable iff (reset)
      (output_valid && !output_ready) |=> (output_valid && $stable(output_data)))
      else begin
         fail_count = fail_count + 1;
         $error("output word changed or dropped while stalled");
      end

endmodule

// File: dv/fc_layer_checker.sv
// Output monitor. Holds the expected words in transfer order and compares
// each word that leaves the layer against the head of that queue.

`timescale 1ns/1ps

module fc_layer_checker (
   input logic                clk,
   input logic                reset,
   input logic                output_valid,
   input logic                output_ready,
   input fc_layer_pkg::data_t output_data
);

   import fc_layer_pkg::*;

   data_t exp_q [$];
   string name_q [$];
   int    error_count = 0;
   int    word_count = 0;

   task automatic expect_word(string name, data_t value);
      exp_q.push_back(value);
      name_q.push_back(name);
   endtask

   function automatic int pending_count();
      return exp_q.size();
   endfunction

   // ********************
   // Compare on transfer
   // ********************

   always @(posedge clk) begin : compare
      data_t expected;
      string name;
      if (!reset && output_valid && output_ready) begin
         if (exp_q.size() == 0) begin
            error_count = error_count + 1;
            $display("Output word %0d arrived with no word left to expect", output_data);
         end else begin
            expected = exp_q.pop_front();
            name = name_q.pop_front();
            word_count = word_count + 1;
            if (output_data !== expected) begin
               error_count = error_count + 1;
               $display("ERROR %s: expected %0d, actual %0d", name, expected, output_data);
            end
         end
      end
   end

endmodule

// File: dv/fc_layer_tb.sv
// Testbench of the fully connected layer. Streams vectors into the DUT,
// queues reference results for the checker and prints the final report.

`timescale 1ns/1ps

module fc_layer_tb;

   import fc_layer_pkg::*;
   import fc_weights_pkg::*;

   localparam bit relu_en = 1'b1;
   localparam int n_vectors = 14;
   localparam int max_cycles = n_vectors * 4 * (N_INPUTS + N_LANES + 8) + 20;

   logic  clk;
   logic  reset;
   logic  input_valid;
   logic  input_ready;
   data_t input_data;
   logic  output_valid;
   logic  output_ready = 1'b1;
   data_t output_data;

   int    seed;
   int    tb_errors;
   int    cycle_count = 0;
   int    in_valid_pct = 100;
   int    out_ready_pct = 100;
   data_t vec [N_INPUTS];

   fc_layer_top #(.relu_en(relu_en)) UUT (
      .clk, .reset, .input_valid, .input_ready, .input_data,
      .output_valid, .output_ready, .output_data
   );

   fc_layer_checker chk (
      .clk, .reset, .output_valid, .output_ready, .output_data
   );

   bind fc_layer_top fc_layer_assertions u_assertions (
      .clk(clk), .reset(reset), .input_ready(input_ready),
      .output_valid(output_valid), .output_ready(output_ready), .output_data(output_data)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic int random_percent();
      int r;
      r = $random(seed);
      return ((r % 100) + 100) % 100;
   endfunction

   // ********************
   // Reference model
   // ********************

   // Saturate each product, then each partial sum, then ReLU
   function automatic data_t reference_neuron(int row);
      longint prod;
      longint sum;
      sum = 0;
      for (int i = 0; i < N_INPUTS; i++) begin
         prod = longint'(vec[i]) * longint'(WEIGHTS[row][i]);
         if (prod > DATA_MAX) prod = DATA_MAX;
         if (prod < DATA_MIN) prod = DATA_MIN;
         sum = sum + prod;
         if (sum > DATA_MAX) sum = DATA_MAX;
         if (sum < DATA_MIN) sum = DATA_MIN;
      end
      if (relu_en && sum < 0) begin
         sum = 0;
      end
      return data_t'(sum);
   endfunction

   task automatic check_bit(string name, logic expected, logic actual);
      if (actual !== expected) begin
         tb_errors = tb_errors + 1;
         $display("ERROR %s: expected %0b, actual %0b", name, expected, actual);
      end
   endtask

   // Kind 0 small values, 1 near the limits, 2 mostly negative
   task automatic send_vector(string name, int kind);
      int idx;
      idx = 0;
      @(posedge clk);
      for (int i = 0; i < N_INPUTS; i++) begin
         case (kind)
            1: vec[i] = ($random(seed) & 1) ? data_t'(30000) : data_t'(-30000);
            2: vec[i] = data_t'($random(seed) % 61 - 40);
            default: vec[i] = data_t'($random(seed) % 101);
         endcase
      end
      for (int l = 0; l < N_LANES; l++) begin
         chk.expect_word(name, reference_neuron(l));
      end
      while (idx < N_INPUTS) begin
         @(negedge clk);
         if (in_valid_pct >= 100 || random_percent() < in_valid_pct) begin
            input_valid = 1'b1;
            input_data = vec[idx];
            if (input_ready) idx++;
         end else begin
            input_valid = 1'b0;
         end
      end
      @(negedge clk);
      input_valid = 1'b0;
   endtask

   task automatic drain_outputs();
      while (chk.pending_count() != 0) @(negedge clk);
   endtask

   always @(negedge clk) begin
      if (out_ready_pct >= 100) output_ready = 1'b1;
      else output_ready = (random_percent() < out_ready_pct);
   end

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= max_cycles) begin
         $display("Timeout: the layer did not finish within %0d cycles", max_cycles);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   // ********************
   // Test sequence
   // ********************

   initial begin
      int total_errors;
      seed = 53882;
      tb_errors = 0;
      reset = 1'b1;
      input_valid = 1'b0;
      input_data = '0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      check_bit("reset_state output_valid", 1'b0, output_valid);
      check_bit("reset_state input_ready", 1'b1, input_ready);

      repeat (4) send_vector("dot_product", 0);
      repeat (2) send_vector("saturation", 1);
      repeat (2) send_vector("relu", 2);
      out_ready_pct = 50;
      repeat (3) send_vector("back_pressure", 0);
      drain_outputs();
      out_ready_pct = 100;
      in_valid_pct = 60;
      repeat (3) send_vector("input_gaps", 0);
      drain_outputs();
      // Room for any extra word to show up
      repeat (10) @(negedge clk);

      total_errors = tb_errors + chk.error_count + UUT.u_assertions.fail_count;
      $display("Checked %0d output words: %0d errors (%0d compare, %0d assertion, %0d other)",
               chk.word_count, total_errors, chk.error_count,
               UUT.u_assertions.fail_count, tb_errors);
      if (total_errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: filelist.f
hw/fc_layer_pkg.sv
hw/fc_weights_pkg.sv
hw/fc_mac_if.sv
hw/fc_sequencer.sv
hw/fc_vector_buffer.sv
hw/fc_weight_rom.sv
hw/fc_mac_lane.sv
hw/fc_output_stage.sv
hw/fc_layer_top.sv
dv/fc_layer_assertions.sv
dv/fc_layer_checker.sv
dv/fc_layer_tb.sv

// File: hw/fc_layer_pkg.sv
// Sizes, word type and sequencer states of the fully connected layer.
// Imported by the RTL stages and by the testbench.

package fc_layer_pkg;

   // ********************
   // Layer dimensions
   // ********************

   localparam int DATA_W = 16;
   localparam int N_INPUTS = 8;
   localparam int N_LANES = 16;

   // Signed fixed point word for inputs, weights, sums and outputs
   typedef logic signed [DATA_W-1:0] data_t;

   // Saturation limits
   localparam data_t DATA_MAX = data_t'(2 ** (DATA_W - 1) - 1);
   localparam data_t DATA_MIN = data_t'(-(2 ** (DATA_W - 1)));

   // ********************
   // Sequencer states
   // ********************

   typedef enum logic [2:0] {
      st_load,
      st_settle,
      st_compute,
      st_output,
      st_clear
   } seq_state_t;

endpackage

// File: hw/fc_layer_top.sv
// Fully connected layer, 8 inputs to 16 outputs with saturating
// fixed point MACs. Streams in one vector, streams out 16 results.

`timescale 1ns/1ps

module fc_layer_top #(
   parameter int n_inputs = fc_layer_pkg::N_INPUTS,
   parameter int n_lanes  = fc_layer_pkg::N_LANES,
   parameter int data_w   = fc_layer_pkg::DATA_W,
   parameter bit relu_en  = 1'b1
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                input_valid,
   output logic                input_ready,
   input  fc_layer_pkg::data_t input_data,
   output logic                output_valid,
   input  logic                output_ready,
   output fc_layer_pkg::data_t output_data
);

   logic [$clog2(n_inputs)-1:0] x_addr;
   logic [$clog2(n_inputs)-1:0] w_addr;
   logic                        x_wr;
   logic                        drain_start;
   logic                        drain_done;

   fc_mac_if #(.n_lanes(n_lanes)) mac ();

   // ********************
   // Control and operands
   // ********************

   fc_sequencer #(.n_inputs(n_inputs)) u_sequencer (
      .clk, .reset, .input_valid, .input_ready,
      .x_addr, .x_wr, .w_addr, .drain_start, .drain_done,
      .mac(mac.seq)
   );

   fc_vector_buffer #(.n_inputs(n_inputs)) u_vector_buffer (
      .clk, .input_data, .x_addr, .x_wr, .mac(mac.buffer)
   );

   fc_weight_rom #(.n_inputs(n_inputs), .n_lanes(n_lanes)) u_weight_rom (
      .clk, .w_addr, .mac(mac.rom)
   );

   // One MAC lane per output neuron
   for (genvar i = 0; i < n_lanes; i++) begin : g_lane
      fc_mac_lane #(.lane(i), .data_w(data_w), .relu_en(relu_en)) u_lane (
         .clk, .reset, .mac(mac.lane)
      );
   end

   fc_output_stage #(.n_lanes(n_lanes)) u_output_stage (
      .clk, .reset, .drain_start, .drain_done,
      .output_valid, .output_ready, .output_data,
      .mac(mac.drain)
   );

endmodule

// File: hw/fc_mac_if.sv
// Operand and control bundle shared by the buffer, weight ROM, MAC lanes,
// sequencer and output stage.

`timescale 1ns/1ps

interface fc_mac_if #(
   parameter int n_lanes = fc_layer_pkg::N_LANES
);

   import fc_layer_pkg::*;

   data_t x_data;
   data_t w_col [n_lanes];
   logic  mac_step;
   logic  clear;
   data_t results [n_lanes];

   modport seq (output mac_step, output clear);

   modport buffer (output x_data);

   modport rom (output w_col);

   modport lane (input x_data, input w_col, input mac_step, input clear, output results);

   // Output stage only reads the finished sums
   modport drain (input results);

endinterface

// File: hw/fc_mac_lane.sv
// One neuron of the layer. Saturating multiply, product register,
// saturating accumulator and an optional ReLU on the sum.

`timescale 1ns/1ps

module fc_mac_lane #(
   parameter int lane    = 0,
   parameter int data_w  = fc_layer_pkg::DATA_W,
   parameter bit relu_en = 1'b1
) (
   input  logic  clk,
   input  logic  reset,
   fc_mac_if.lane mac
);

   import fc_layer_pkg::*;

   logic signed [2*data_w-1:0] product_full;
   data_t                      product_sat;
   data_t                      prod_q;
   logic                       step_d1;
   logic                       step_d2;
   logic signed [data_w:0]     sum_wide;
   data_t                      sum_sat;
   data_t                      acc;
   data_t                      relu_out;

   // ********************
   // Multiply
   // ********************

   always_comb begin
      product_full = (2*data_w)'(mac.x_data) * (2*data_w)'(mac.w_col[lane]);
      if (product_full > (2*data_w)'(DATA_MAX)) begin
         product_sat = DATA_MAX;
      end else if (product_full < (2*data_w)'(DATA_MIN)) begin
         product_sat = DATA_MIN;
      end else begin
         product_sat = data_t'(product_full);
      end
   end

   // Step strobe lines up with the registered product two cycles later
   always_ff @(posedge clk) begin
      prod_q <= product_sat;
      if (reset) begin
         step_d1 <= 1'b0;
         step_d2 <= 1'b0;
      end else begin
         step_d1 <= mac.mac_step;
         step_d2 <= step_d1;
      end
   end

   // ********************
   // Accumulate
   // ********************

   always_comb begin
      sum_wide = (data_w+1)'(acc) + (data_w+1)'(prod_q);
      if (sum_wide > (data_w+1)'(DATA_MAX)) begin
         sum_sat = DATA_MAX;
      end else if (sum_wide < (data_w+1)'(DATA_MIN)) begin
         sum_sat = DATA_MIN;
      end else begin
         sum_sat = data_t'(sum_wide);
      end
   end

   always_ff @(posedge clk) begin
      if (reset || mac.clear) begin
         acc <= '0;
      end else if (step_d2) begin
         acc <= sum_sat;
      end
   end

   // Negative sums read as zero when ReLU is on
   always_comb begin
      if (relu_en && acc[data_w-1]) begin
         relu_out = '0;
      end else begin
         relu_out = acc;
      end
   end

   assign mac.results[lane] = relu_out;

endmodule

// File: hw/fc_output_stage.sv
// Output serializer. Sends the lane results one word at a time under the
// output valid/ready handshake, then reports completion to the sequencer.

`timescale 1ns/1ps

module fc_output_stage #(
   parameter int n_lanes = fc_layer_pkg::N_LANES
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                drain_start,
   output logic                drain_done,
   output logic                output_valid,
   input  logic                output_ready,
   output fc_layer_pkg::data_t output_data,
   fc_mac_if.drain             mac
);

   localparam int sel_bits = $clog2(n_lanes);

   logic                busy;
   logic [sel_bits-1:0] sel;

   // Word stays put until it is taken
   assign output_valid = busy;
   assign output_data  = mac.results[sel];

   always_ff @(posedge clk) begin
      if (reset) begin
         busy       <= 1'b0;
         sel        <= '0;
         drain_done <= 1'b0;
      end else begin
         drain_done <= 1'b0;
         if (drain_start) begin
            busy <= 1'b1;
            sel  <= '0;
         end else if (busy && output_ready) begin
            if (sel == sel_bits'(n_lanes - 1)) begin
               busy       <= 1'b0;
               sel        <= '0;
               drain_done <= 1'b1;
            end else begin
               sel <= sel + 1'b1;
            end
         end
      end
   end

endmodule

// File: hw/fc_sequencer.sv
// Control FSM of the layer. Loads the input vector, walks the MAC steps,
// hands the sums to the output stage and clears the lanes afterwards.

`timescale 1ns/1ps

module fc_sequencer #(
   parameter int n_inputs = fc_layer_pkg::N_INPUTS
) (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        input_valid,
   output logic                        input_ready,
   output logic [$clog2(n_inputs)-1:0] x_addr,
   output logic                        x_wr,
   output logic [$clog2(n_inputs)-1:0] w_addr,
   output logic                        drain_start,
   input  logic                        drain_done,
   fc_mac_if.seq                       mac
);

   import fc_layer_pkg::*;

   localparam int addr_bits = $clog2(n_inputs);
   // Steps run one past the last address plus two pipeline cycles
   localparam int step_bits = $clog2(n_inputs + 2);

   seq_state_t           state;
   logic [addr_bits-1:0] in_cnt;
   logic [step_bits-1:0] step_cnt;
   logic                 last_step;

   assign last_step = (step_cnt == step_bits'(n_inputs + 1));

   // ********************
   // Decoded outputs
   // ********************

   always_comb begin
      input_ready  = (state == st_load);
      x_wr         = input_ready && input_valid;
      mac.mac_step = (state == st_compute) && (step_cnt < step_bits'(n_inputs));
      mac.clear    = (state == st_clear);
      drain_start  = (state == st_compute) && last_step;
      w_addr       = step_cnt[addr_bits-1:0];
      if (state == st_load) begin
         x_addr = in_cnt;
      end else begin
         x_addr = step_cnt[addr_bits-1:0];
      end
   end

   // ********************
   // State register
   // ********************

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= st_load;
         in_cnt   <= '0;
         step_cnt <= '0;
      end else begin
         case (state)
            st_load: begin
               if (input_valid) begin
                  if (in_cnt == addr_bits'(n_inputs - 1)) begin
                     in_cnt <= '0;
                     state  <= st_settle;
                  end else begin
                     in_cnt <= in_cnt + 1'b1;
                  end
               end
            end
            st_settle: begin
               step_cnt <= '0;
               state    <= st_compute;
            end
            st_compute: begin
               if (last_step) begin
                  step_cnt <= '0;
                  state    <= st_output;
               end else begin
                  step_cnt <= step_cnt + 1'b1;
               end
            end
            st_output: begin
               // Wait for the last word to leave
               if (drain_done) begin
                  state <= st_clear;
               end
            end
            st_clear: begin
               state <= st_load;
            end
            default: begin
               state <= st_load;
            end
         endcase
      end
   end

endmodule

// File: hw/fc_vector_buffer.sv
// Input vector memory. Written during load, read one word per MAC step
// with one cycle of read latency.

`timescale 1ns/1ps

module fc_vector_buffer #(
   parameter int n_inputs = fc_layer_pkg::N_INPUTS
) (
   input  logic                        clk,
   input  fc_layer_pkg::data_t         input_data,
   input  logic [$clog2(n_inputs)-1:0] x_addr,
   input  logic                        x_wr,
   fc_mac_if.buffer                    mac
);

   import fc_layer_pkg::*;

   data_t mem [n_inputs];

   always_ff @(posedge clk) begin
      if (x_wr) begin
         mem[x_addr] <= input_data;
      end
      // Registered read port
      mac.x_data <= mem[x_addr];
   end

endmodule

// File: hw/fc_weight_rom.sv
// Weight ROM. Returns one column of the weight table, a weight for every
// lane, one cycle after the address.

`timescale 1ns/1ps

module fc_weight_rom #(
   parameter int n_inputs = fc_layer_pkg::N_INPUTS,
   parameter int n_lanes  = fc_layer_pkg::N_LANES
) (
   input  logic                        clk,
   input  logic [$clog2(n_inputs)-1:0] w_addr,
   fc_mac_if.rom                       mac
);

   import fc_weights_pkg::*;

   // Column read, lane l gets row l of the table
   always_ff @(posedge clk) begin
      for (int l = 0; l < n_lanes; l++) begin
         mac.w_col[l] <= WEIGHTS[l][w_addr];
      end
   end

endmodule

// File: hw/fc_weights_pkg.sv
// Constant weight table of the layer, one row per output neuron.
// Read by the weight ROM and by the testbench reference model.

package fc_weights_pkg;

   import fc_layer_pkg::*;

   // Row index is the lane, column index is the input position
   localparam data_t WEIGHTS [N_LANES][N_INPUTS] = '{
      '{-16'sd5, 16'sd9, 16'sd40, -16'sd85, 16'sd93, 16'sd1, 16'sd53, -16'sd41},
      '{-16'sd92, 16'sd112, -16'sd63, 16'sd12, 16'sd13, -16'sd3, -16'sd23, -16'sd94},
      '{-16'sd74, -16'sd23, -16'sd33, 16'sd28, 16'sd68, -16'sd39, 16'sd90, -16'sd114},
      '{16'sd68, -16'sd88, -16'sd114, -16'sd53, -16'sd32, -16'sd67, -16'sd92, 16'sd91},
      '{16'sd70, 16'sd77, -16'sd121, 16'sd35, -16'sd50, 16'sd60, 16'sd122, -16'sd14},
      '{16'sd44, -16'sd69, 16'sd126, -16'sd71, 16'sd57, -16'sd24, -16'sd37, 16'sd111},
      '{16'sd81, 16'sd58, 16'sd11, 16'sd22, -16'sd109, -16'sd27, 16'sd36, 16'sd88},
      '{16'sd14, 16'sd50, -16'sd93, 16'sd110, 16'sd111, -16'sd56, 16'sd73, 16'sd54},
      '{-16'sd107, 16'sd80, -16'sd39, -16'sd29, 16'sd12, -16'sd44, 16'sd86, -16'sd71},
      '{16'sd15, 16'sd84, -16'sd14, -16'sd56, -16'sd68, 16'sd78, -16'sd72, -16'sd114},
      '{16'sd8, 16'sd67, 16'sd36, 16'sd28, -16'sd87, -16'sd56, -16'sd12, 16'sd55},
      '{16'sd122, 16'sd23, 16'sd37, 16'sd105, 16'sd95, -16'sd18, 16'sd31, 16'sd116},
      '{-16'sd65, 16'sd121, -16'sd40, 16'sd75, -16'sd51, -16'sd82, -16'sd124, 16'sd92},
      '{-16'sd126, -16'sd9, -16'sd91, -16'sd65, -16'sd59, -16'sd35, -16'sd51, 16'sd77},
      '{-16'sd96, 16'sd113, -16'sd23, -16'sd55, -16'sd71, 16'sd93, -16'sd128, -16'sd77},
      // Large weights, these push the last lane into saturation
      '{-16'sd3723, -16'sd4699, 16'sd21532, -16'sd25004,
        -16'sd16876, -16'sd14916, -16'sd4535, 16'sd1619}
   };

endpackage
